/* files.f */
+incdir+include
src/regmst_pkg.sv
src/apb_access_fsm.sv
src/access_router.sv
src/debug_reg_bank.sv
src/regmst_top.sv
sim/regmst_tb_clk.sv
sim/regmst_tb.sv

/* run.sh */
#!/bin/sh
# Verilator build and run, the simulation log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps -f files.f \
    --top-module regmst_tb -o regmst_sim > build.log 2>&1 \
    && ./obj_dir/regmst_sim > sim.log 2>&1 \
    && ! grep -q "Errors found" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

/* sim/regmst_tb.sv */
`timescale 1ns/1ps
`include "regmst_macros.svh"

module regmst_tb;

    localparam int          N_EXT      = 8;
    localparam int          N_XFER     = 22 + N_EXT;
    localparam logic [63:0] LO_ADDR    = `REGMST_DB_BASE;
    localparam logic [63:0] HI_ADDR    = `REGMST_DB_BASE + 64'd4;
    localparam logic [63:0] THR_ADDR   = `REGMST_DB_BASE + 64'd8;
    localparam logic [63:0] STAT_ADDR  = `REGMST_DB_BASE + 64'd12;
    localparam logic [63:0] EMPTY_ADDR = 64'h0000_0003_0000_0000;
    localparam logic [31:0] RSP_MASK   = 32'h5A5A_5A5A;

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [63:0] paddr;
    logic [31:0] pwdata;
    logic        pready;
    logic        pslverr;
    logic [31:0] prdata;
    logic        ext_req_vld;
    logic        ext_wr_en;
    logic        ext_rd_en;
    logic [63:0] ext_addr;
    logic [31:0] ext_wr_data;
    logic        ext_ack_vld = 1'b0;
    logic [31:0] ext_rd_data = '0;
    logic        soft_rst;

    integer      seed = 99;
    int          errors = 0;
    int          xfers = 0;

    // what the current transfer should look like
    logic        exp_ext;
    logic        exp_rd;
    logic        exp_err;
    logic        exp_soft;
    logic [31:0] exp_rdata;
    logic        cur_wr;
    logic [63:0] cur_addr;
    logic [31:0] cur_wdata;
    logic        acc_first;
    int          ext_base;

    // external responder state
    logic        rsp_on;
    int          ack_delay;
    int          ack_cnt = 0;
    logic        rsp_pend = 1'b0;
    logic [31:0] rsp_data = '0;
    int          ext_total = 0;

    regmst_tb_clk clk_gen_i (
        .clk    (clk),
        .rst_n  (rst_n)
    );

    regmst_top dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .psel_i         (psel),
        .penable_i      (penable),
        .pwrite_i       (pwrite),
        .paddr_i        (paddr),
        .pwdata_i       (pwdata),
        .pready_o       (pready),
        .pslverr_o      (pslverr),
        .prdata_o       (prdata),
        .ext_req_vld_o  (ext_req_vld),
        .ext_wr_en_o    (ext_wr_en),
        .ext_rd_en_o    (ext_rd_en),
        .ext_addr_o     (ext_addr),
        .ext_wr_data_o  (ext_wr_data),
        .ext_ack_vld_i  (ext_ack_vld),
        .ext_rd_data_i  (ext_rd_data),
        .soft_rst_o     (soft_rst)
    );

    // dispatcher model answers ack_delay cycles after the request
    always @(negedge clk) begin
        ext_ack_vld = 1'b0;
        if (ext_req_vld) begin
            ext_total++;
            if (rsp_on) begin
                rsp_pend = 1'b1;
                ack_cnt  = ack_delay;
                rsp_data = ext_addr[31:0] ^ RSP_MASK;
            end
        end else if (rsp_pend) begin
            ack_cnt--;
            if (ack_cnt == 0) begin
                rsp_pend    = 1'b0;
                ext_ack_vld = 1'b1;
                ext_rd_data = rsp_data;
            end
        end
    end

    a_reset_vals: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rst_n) |-> !pready && !soft_rst)
        else begin
            errors++;
            $display("ERR pready_o %h soft_rst_o %h after reset exp 0",
                     $sampled(pready), $sampled(soft_rst));
        end

    a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
        pready && (exp_rd || exp_err) |-> prdata == exp_rdata)
        else begin
            errors++;
            $display("ERR prdata_o got %h exp %h", $sampled(prdata), exp_rdata);
        end

    a_slverr: assert property (@(posedge clk) disable iff (!rst_n)
        pready |-> pslverr == exp_err)
        else begin
            errors++;
            $display("ERR pslverr_o got %h exp %h", $sampled(pslverr), exp_err);
        end

    a_soft_rst: assert property (@(posedge clk) disable iff (!rst_n)
        pready |-> soft_rst == exp_soft)
        else begin
            errors++;
            $display("ERR soft_rst_o got %h exp %h", $sampled(soft_rst), exp_soft);
        end

    // internal targets answer two cycles after the first access cycle
    a_int_latency: assert property (@(posedge clk) disable iff (!rst_n)
        pready && !exp_ext |-> $past(acc_first, 2))
        else begin
            errors++;
            $display("internal access to %h did not answer two cycles after access", cur_addr);
        end

    a_ext_count: assert property (@(posedge clk) disable iff (!rst_n)
        pready |-> (ext_total - ext_base) == (exp_ext ? 1 : 0))
        else begin
            errors++;
            $display("wrong number of external requests (%0d) for address %h",
                     ext_total - ext_base, cur_addr);
        end

    a_no_ext_int: assert property (@(posedge clk) disable iff (!rst_n)
        ext_req_vld |-> exp_ext)
        else begin
            errors++;
            $display("external request fired for internal address %h", cur_addr);
        end

    a_ext_dir: assert property (@(posedge clk) disable iff (!rst_n)
        ext_req_vld |-> ext_wr_en == cur_wr && ext_rd_en == !cur_wr)
        else begin
            errors++;
            $display("ERR ext_wr_en_o %h ext_rd_en_o %h exp write %h",
                     $sampled(ext_wr_en), $sampled(ext_rd_en), cur_wr);
        end

    a_ext_addr: assert property (@(posedge clk) disable iff (!rst_n)
        ext_req_vld |-> ext_addr == cur_addr && ext_wr_data == cur_wdata)
        else begin
            errors++;
            $display("ERR ext_addr_o %h ext_wr_data_o %h exp %h %h",
                     $sampled(ext_addr), $sampled(ext_wr_data), cur_addr, cur_wdata);
        end

    a_ext_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !ext_req_vld |-> !ext_wr_en && !ext_rd_en && ext_addr == '0 && ext_wr_data == '0)
        else begin
            errors++;
            $display("ERR ext_addr_o %h ext_wr_data_o %h while no request exp 0",
                     $sampled(ext_addr), $sampled(ext_wr_data));
        end

    // one APB transfer with the expected prdata and pslverr
    task automatic apb_xfer(input logic wr, input logic [63:0] addr, input logic [31:0] wdata,
                            input logic [31:0] rd_exp, input logic err_exp);
        @(negedge clk);
        cur_wr    = wr;
        cur_addr  = addr;
        cur_wdata = wdata;
        exp_ext   = addr < `REGMST_EXT_LIMIT;
        exp_rd    = !wr;
        exp_rdata = rd_exp;
        exp_err   = err_exp;
        if (wr && addr == STAT_ADDR) begin
            exp_soft = wdata[0];
        end
        ext_base = ext_total;
        // setup phase
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable   = 1'b1;
        acc_first = 1'b1;
        @(negedge clk);
        acc_first = 1'b0;
        while (!pready) begin
            @(negedge clk);
        end
        psel    = 1'b0;
        penable = 1'b0;
        xfers++;
    endtask

    initial begin
        logic [31:0] rnd;
        logic [63:0] addr;
        logic        wr;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        exp_ext   = 1'b0;
        exp_rd    = 1'b0;
        exp_err   = 1'b0;
        exp_soft  = 1'b0;
        exp_rdata = '0;
        cur_wr    = 1'b0;
        cur_addr  = '0;
        cur_wdata = '0;
        acc_first = 1'b0;
        ext_base  = 0;
        rsp_on    = 1'b1;
        ack_delay = 1;
        wait (rst_n);
        repeat (2) @(negedge clk);

        // reset values of threshold and status
        apb_xfer(1'b0, THR_ADDR, '0, 32'h0000_0063, 1'b0);
        apb_xfer(1'b0, STAT_ADDR, '0, '0, 1'b0);

        // threshold readback and restore before the external tests
        rnd = $random(seed);
        apb_xfer(1'b1, THR_ADDR, rnd, '0, 1'b0);
        apb_xfer(1'b0, THR_ADDR, '0, rnd, 1'b0);
        apb_xfer(1'b1, THR_ADDR, 32'h0000_0063, '0, 1'b0);
        apb_xfer(1'b0, EMPTY_ADDR, '0, '0, 1'b0);
        apb_xfer(1'b1, EMPTY_ADDR, rnd, '0, 1'b0);
        apb_xfer(1'b0, EMPTY_ADDR, '0, '0, 1'b0);

        // random external traffic
        for (int i = 0; i < N_EXT; i++) begin
            rnd         = $random(seed);
            wr          = rnd[0];
            addr[63:32] = {31'd0, rnd[1]};
            addr[31:0]  = $random(seed) & ~32'h3;
            rnd         = wr ? $random(seed) : 32'h0;
            ack_delay   = 1 + ($unsigned($random(seed)) % 20);
            apb_xfer(wr, addr, rnd, addr[31:0] ^ RSP_MASK, 1'b0);
        end

        // timeouts with a silent dispatcher and a nonzero high address word
        rsp_on = 1'b0;
        apb_xfer(1'b1, THR_ADDR, 32'd10, '0, 1'b0);
        rnd  = $random(seed);
        addr = {32'h0000_0001, rnd & ~32'h3};
        apb_xfer(1'b0, addr, '0, '0, 1'b1);
        // occur set and acc_type from the read
        apb_xfer(1'b0, STAT_ADDR, '0, 32'h0000_0002, 1'b0);
        rnd  = $random(seed);
        addr = {32'h0000_0001, rnd & ~32'h3};
        apb_xfer(1'b1, addr, rnd, '0, 1'b1);
        apb_xfer(1'b0, STAT_ADDR, '0, 32'h0000_0006, 1'b0);
        apb_xfer(1'b0, LO_ADDR, '0, addr[31:0], 1'b0);
        apb_xfer(1'b0, HI_ADDR, '0, addr[63:32], 1'b0);
        rsp_on = 1'b1;

        // soft reset raises and lowers soft_rst_o and holds the snapshot at zero
        apb_xfer(1'b1, STAT_ADDR, 32'h0000_0003, '0, 1'b0);
        apb_xfer(1'b0, STAT_ADDR, '0, 32'h0000_0007, 1'b0);
        apb_xfer(1'b0, HI_ADDR, '0, '0, 1'b0);
        apb_xfer(1'b1, STAT_ADDR, 32'h0000_0002, '0, 1'b0);
        apb_xfer(1'b0, STAT_ADDR, '0, 32'h0000_0006, 1'b0);
        // occur cleared by software
        apb_xfer(1'b1, STAT_ADDR, 32'h0000_0000, '0, 1'b0);
        apb_xfer(1'b0, STAT_ADDR, '0, 32'h0000_0004, 1'b0);

        repeat (2) @(negedge clk);
        $display("transfers: %0d  errors: %0d", xfers, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // watchdog allows 150 cycles per transfer plus reset
    initial begin
        repeat (N_XFER * 150 + 4) @(posedge clk);
        $display("watchdog expired, only %0d of %0d transfers completed", xfers, N_XFER);
        $display("transfers: %0d  errors: %0d", xfers, errors);
        $display("Errors found");
        $finish;
    end

endmodule

/* sim/regmst_tb_clk.sv */
`timescale 1ns/1ps

module regmst_tb_clk (
    output logic clk,
    output logic rst_n
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset low for four cycles, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* src/regmst_top.sv */
`timescale 1ns/1ps
`include "regmst_macros.svh"

module regmst_top import regmst_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  logic [`REGMST_ADDR_W-1:0]   paddr_i,
    input  logic [`REGMST_DATA_W-1:0]   pwdata_i,
    output logic                        pready_o,
    output logic                        pslverr_o,
    output logic [`REGMST_DATA_W-1:0]   prdata_o,
    output logic                        ext_req_vld_o,
    output logic                        ext_wr_en_o,
    output logic                        ext_rd_en_o,
    output logic [`REGMST_ADDR_W-1:0]   ext_addr_o,
    output logic [`REGMST_DATA_W-1:0]   ext_wr_data_o,
    input  logic                        ext_ack_vld_i,
    input  logic [`REGMST_DATA_W-1:0]   ext_rd_data_i,
    output logic                        soft_rst_o
);

    reg_req_t                   fsm_req;
    reg_rsp_t                   fsm_rsp;
    bank_req_t                  bank_req;
    err_event_t                 err_evt;
    logic [`REGMST_DATA_W-1:0]  bank_rdata;
    logic [`REGMST_DATA_W-1:0]  tmr_thr;

    apb_access_fsm fsm_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .psel_i     (psel_i),
        .penable_i  (penable_i),
        .pwrite_i   (pwrite_i),
        .paddr_i    (paddr_i),
        .pwdata_i   (pwdata_i),
        .pready_o   (pready_o),
        .pslverr_o  (pslverr_o),
        .prdata_o   (prdata_o),
        .req_o      (fsm_req),
        .rsp_i      (fsm_rsp),
        .tmr_thr_i  (tmr_thr),
        .err_evt_o  (err_evt)
    );

    access_router router_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_i          (fsm_req),
        .rsp_o          (fsm_rsp),
        .bank_req_o     (bank_req),
        .bank_rdata_i   (bank_rdata),
        .ext_req_vld_o  (ext_req_vld_o),
        .ext_wr_en_o    (ext_wr_en_o),
        .ext_rd_en_o    (ext_rd_en_o),
        .ext_addr_o     (ext_addr_o),
        .ext_wr_data_o  (ext_wr_data_o),
        .ext_ack_vld_i  (ext_ack_vld_i),
        .ext_rd_data_i  (ext_rd_data_i)
    );

    debug_reg_bank bank_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .bank_req_i     (bank_req),
        .bank_rdata_o   (bank_rdata),
        .err_evt_i      (err_evt),
        .tmr_thr_o      (tmr_thr),
        .soft_rst_o     (soft_rst_o)
    );

endmodule

/* src/debug_reg_bank.sv */
`timescale 1ns/1ps
`include "regmst_macros.svh"

module debug_reg_bank import regmst_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  bank_req_t                   bank_req_i,
    output logic [`REGMST_DATA_W-1:0]   bank_rdata_o,
    input  err_event_t                  err_evt_i,
    output logic [`REGMST_DATA_W-1:0]   tmr_thr_o,
    output logic                        soft_rst_o
);

    err_addr_u                  err_addr_q;
    err_addr_u                  snap_q;
    logic [`REGMST_DATA_W-1:0]  thr_q;
    err_stat_t                  stat_q;
    err_stat_t                  stat_wr;
    logic                       rd_lo;
    logic                       wr_thr;
    logic                       wr_stat;

    assign rd_lo   = bank_req_i.rd && (bank_req_i.idx == DB_IDX_W'(0));
    assign wr_thr  = bank_req_i.wr && (bank_req_i.idx == DB_IDX_W'(2));
    assign wr_stat = bank_req_i.wr && (bank_req_i.idx == DB_IDX_W'(3));

    assign stat_wr = err_stat_t'(bank_req_i.wdata[$bits(err_stat_t)-1:0]);

    // address of the transfer that timed out, read-only to software
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_addr_q <= '0;
        end else if (err_evt_i.tmout) begin
            err_addr_q.full <= err_evt_i.addr;
        end
    end

    // low half read freezes the whole word for the following high read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            snap_q <= '0;
        end else if (stat_q.soft_rst) begin
            snap_q <= '0;
        end else if (rd_lo) begin
            snap_q <= err_addr_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            thr_q <= `REGMST_TMR_THR_RST;
        end else if (wr_thr) begin
            thr_q <= bank_req_i.wdata;
        end
    end

    // status fields
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stat_q <= '0;
        end else begin
            if (wr_stat) begin
                stat_q.soft_rst <= stat_wr.soft_rst;
            end
            // software write beats a timeout in the same cycle
            if (wr_stat) begin
                stat_q.occur <= stat_wr.occur;
            end else if (err_evt_i.tmout) begin
                stat_q.occur <= 1'b1;
            end
            if (err_evt_i.tmout) begin
                stat_q.acc_type <= err_evt_i.acc_wr;
            end
        end
    end

    // read mux, index 0 shows the live low half
    always_comb begin
        case (bank_req_i.idx)
            DB_IDX_W'(0): bank_rdata_o = err_addr_q.half.lo;
            DB_IDX_W'(1): bank_rdata_o = snap_q.half.hi;
            DB_IDX_W'(2): bank_rdata_o = thr_q;
            default:      bank_rdata_o = `REGMST_DATA_W'(stat_q);
        endcase
    end

    assign tmr_thr_o  = thr_q;
    assign soft_rst_o = stat_q.soft_rst;

endmodule

/* src/access_router.sv */
`timescale 1ns/1ps
`include "regmst_macros.svh"

module access_router import regmst_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  reg_req_t                    req_i,
    output reg_rsp_t                    rsp_o,
    output bank_req_t                   bank_req_o,
    input  logic [`REGMST_DATA_W-1:0]   bank_rdata_i,
    output logic                        ext_req_vld_o,
    output logic                        ext_wr_en_o,
    output logic                        ext_rd_en_o,
    output logic [`REGMST_ADDR_W-1:0]   ext_addr_o,
    output logic [`REGMST_DATA_W-1:0]   ext_wr_data_o,
    input  logic                        ext_ack_vld_i,
    input  logic [`REGMST_DATA_W-1:0]   ext_rd_data_i
);

    logic ext_sel;
    logic db_sel;
    logic empty_sel;
    logic ext_req;
    logic ext_ack;
    logic int_ack;
    logic ext_pend_q;

    // address decode, request address is stable for the whole transfer
    assign ext_sel   = req_i.addr < `REGMST_EXT_LIMIT;
    assign db_sel    = (req_i.addr >= `REGMST_DB_BASE) &&
                       (req_i.addr < `REGMST_DB_BASE + 64'(4 * `REGMST_DB_REG_NUM));
    assign empty_sel = !ext_sel && !db_sel;

    // external port, strobes pulse with the request
    assign ext_req       = req_i.vld && ext_sel;
    assign ext_req_vld_o = ext_req;
    assign ext_wr_en_o   = ext_req && req_i.wr;
    assign ext_rd_en_o   = ext_req && !req_i.wr;
    assign ext_addr_o    = ext_req ? req_i.addr : '0;
    assign ext_wr_data_o = ext_req ? req_i.wdata : '0;

    // a new request always replaces the outstanding flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ext_pend_q <= 1'b0;
        end else if (req_i.vld) begin
            ext_pend_q <= ext_sel;
        end else if (ext_ack_vld_i) begin
            ext_pend_q <= 1'b0;
        end
    end

    // stray acks dropped here
    assign ext_ack = ext_ack_vld_i && ext_pend_q;

    assign bank_req_o.rd    = req_i.vld && db_sel && !req_i.wr;
    assign bank_req_o.wr    = req_i.vld && db_sel && req_i.wr;
    assign bank_req_o.idx   = req_i.addr[2 +: DB_IDX_W];
    assign bank_req_o.wdata = req_i.wdata;

    // debug registers and empty slots answer in the request cycle
    assign int_ack   = req_i.vld && (db_sel || empty_sel);
    assign rsp_o.ack = int_ack || ext_ack;

    always_comb begin
        if (req_i.vld && db_sel) begin
            rsp_o.rdata = bank_rdata_i;
        end else if (ext_ack) begin
            rsp_o.rdata = ext_rd_data_i;
        end else begin
            rsp_o.rdata = '0;
        end
    end

endmodule

/* src/apb_access_fsm.sv */
`timescale 1ns/1ps
`include "regmst_macros.svh"

module apb_access_fsm import regmst_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  logic [`REGMST_ADDR_W-1:0]   paddr_i,
    input  logic [`REGMST_DATA_W-1:0]   pwdata_i,
    output logic                        pready_o,
    output logic                        pslverr_o,
    output logic [`REGMST_DATA_W-1:0]   prdata_o,
    output reg_req_t                    req_o,
    input  reg_rsp_t                    rsp_i,
    input  logic [`REGMST_DATA_W-1:0]   tmr_thr_i,
    output err_event_t                  err_evt_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_RESP
    } state_t;

    state_t                     state_q;
    logic                       req_vld_q;
    logic                       req_wr_q;
    logic [`REGMST_ADDR_W-1:0]  req_addr_q;
    logic [`REGMST_DATA_W-1:0]  req_wdata_q;
    logic [`REGMST_DATA_W-1:0]  tmr_cnt_q;
    logic                       start;
    logic                       tmout;
    logic                       done;

    // access phase seen while idle
    assign start = (state_q == ST_IDLE) && psel_i && penable_i;

    // an ack in the same cycle wins over the timeout
    assign tmout = (state_q == ST_WAIT) && !rsp_i.ack && (tmr_cnt_q == tmr_thr_i);
    assign done  = (state_q == ST_WAIT) && (rsp_i.ack || tmout);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= ST_IDLE;
            req_vld_q <= 1'b0;
            tmr_cnt_q <= '0;
            pready_o  <= 1'b0;
            pslverr_o <= 1'b0;
            prdata_o  <= '0;
        end else begin
            req_vld_q <= start;
            case (state_q)
                ST_IDLE: begin
                    if (start) begin
                        state_q   <= ST_WAIT;
                        tmr_cnt_q <= '0;
                    end
                end
                ST_WAIT: begin
                    tmr_cnt_q <= tmr_cnt_q + 1'b1;
                    if (done) begin
                        state_q   <= ST_RESP;
                        pready_o  <= 1'b1;
                        pslverr_o <= tmout;
                        prdata_o  <= tmout ? '0 : rsp_i.rdata;
                    end
                end
                ST_RESP: begin
                    // pready held for one cycle only
                    state_q   <= ST_IDLE;
                    pready_o  <= 1'b0;
                    pslverr_o <= 1'b0;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // transfer captured once, held stable until the next one
    always_ff @(posedge clk) begin
        if (start) begin
            req_wr_q    <= pwrite_i;
            req_addr_q  <= paddr_i;
            req_wdata_q <= pwdata_i;
        end
    end

    assign req_o = '{vld: req_vld_q, wr: req_wr_q, addr: req_addr_q, wdata: req_wdata_q};

    assign err_evt_o = '{tmout: tmout, acc_wr: req_wr_q, addr: req_addr_q};

endmodule

/* src/regmst_pkg.sv */
`include "regmst_macros.svh"

package regmst_pkg;

    localparam int DB_IDX_W = $clog2(`REGMST_DB_REG_NUM);

    // request from the APB side, vld pulses once per transfer
    typedef struct packed {
        logic                       vld;
        logic                       wr;
        logic [`REGMST_ADDR_W-1:0]  addr;
        logic [`REGMST_DATA_W-1:0]  wdata;
    } reg_req_t;

    typedef struct packed {
        logic                       ack;
        logic [`REGMST_DATA_W-1:0]  rdata;
    } reg_rsp_t;

    // one access to the debug bank
    typedef struct packed {
        logic                       rd;
        logic                       wr;
        logic [DB_IDX_W-1:0]        idx;
        logic [`REGMST_DATA_W-1:0]  wdata;
    } bank_req_t;

    // timeout record, tmout pulses once
    typedef struct packed {
        logic                       tmout;
        logic                       acc_wr;
        logic [`REGMST_ADDR_W-1:0]  addr;
    } err_event_t;

    typedef struct packed {
        logic acc_type;
        logic occur;
        logic soft_rst;
    } err_stat_t;

    // error address, whole word or two bus-sized halves
    typedef union packed {
        logic [`REGMST_ADDR_W-1:0] full;
        struct packed {
            logic [`REGMST_DATA_W-1:0] hi;
            logic [`REGMST_DATA_W-1:0] lo;
        } half;
    } err_addr_u;

endpackage

/* include/regmst_macros.svh */
`ifndef REGMST_MACROS_SVH
`define REGMST_MACROS_SVH

// bus widths, shared by APB and the external register port
`define REGMST_ADDR_W       64
`define REGMST_DATA_W       32

// debug registers inside the master
`define REGMST_DB_REG_NUM   4

// external register space runs from 0 up to this byte address
`define REGMST_EXT_LIMIT    64'h0000_0002_0000_0110

// debug register 0, the others follow at word steps
// 0 snapshot low, 1 snapshot high, 2 threshold, 3 status
`define REGMST_DB_BASE      64'h0000_0002_0000_1000

// wait timer threshold after reset (99 cycles)
`define REGMST_TMR_THR_RST  32'h0000_0063

`endif
